//--- logic/streamer_pkg.sv
/* Shared widths, FIFO depths and channel indices of the memory streamer.
   Addresses are byte addresses; every access is one full DATA_W word. */

package streamer_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned LEN_W  = 16;

  // Load FIFO depth doubles as the outstanding read credit
  localparam int unsigned LOAD_FIFO_DEPTH  = 4;
  localparam int unsigned STORE_FIFO_DEPTH = 2;
  localparam int unsigned LOAD_CNT_W       = $clog2(LOAD_FIFO_DEPTH + 1);

  // Memory channels seen by the arbiter
  localparam int unsigned N_CHAN = 3;
  localparam int unsigned CHAN_W = $clog2(N_CHAN);
  localparam int unsigned CH_X   = 0;
  localparam int unsigned CH_W   = 1;
  localparam int unsigned CH_Z   = 2;

  typedef logic [DATA_W-1:0] data_t;

  // One memory request as it waits in the store FIFO
  typedef struct packed {
    logic [ADDR_W-1:0] add;
    logic              wen;
    logic [BE_W-1:0]   be;
    data_t             data;
  } mem_req_t;

endpackage

//--- logic/tcdm_if.sv
/* One channel of the memory port. wen high means read.
   A read answers with r_valid one cycle after its grant; writes give no response. */

`timescale 1ns/10ps

interface tcdm_if
  import streamer_pkg::*;
();

  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] add;
  logic              wen;
  logic [BE_W-1:0]   be;
  data_t             data;
  logic              r_valid;
  data_t             r_data;

  // Source or sink side
  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_valid, r_data
  );

  // Arbiter side
  modport target (
    input  req, add, wen, be, data,
    output gnt, r_valid, r_data
  );

endinterface

//--- logic/stream_fifo.sv
/* Circular-buffer FIFO, any DEPTH of 1 or more. Push while full and pop while
   empty are ignored. The head word is visible on pop_data_o while not empty. */

`timescale 1ns/10ps

module stream_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  payload_t                   push_data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output payload_t                   pop_data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap explicitly so DEPTH need not be a power of two
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];

endmodule

//--- logic/stream_source.sv
/* Load channel: reads len_i words at base_i + i*stride_i and streams them in order.
   Reads in flight plus buffered words never exceed LOAD_FIFO_DEPTH.
   A start with len_i of zero only pulses done. */

`timescale 1ns/10ps

module stream_source
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              enable_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_i,
  input  logic [LEN_W-1:0]  stride_i,
  input  logic [LEN_W-1:0]  len_i,
  output logic              busy_o,
  output logic              done_o,
  tcdm_if.initiator         tcdm,
  output logic              valid_o,
  input  logic              ready_i,
  output data_t             data_o
);

  logic                  busy_q;
  logic                  done_q;
  logic [ADDR_W-1:0]     addr_q;
  logic [LEN_W-1:0]      stride_q;
  logic [LEN_W-1:0]      req_left_q;
  logic [LEN_W-1:0]      out_left_q;
  logic [LOAD_CNT_W-1:0] outst_q;
  logic [LOAD_CNT_W-1:0] fifo_count;
  logic                  fifo_empty;
  logic                  credit_ok;
  logic                  issue;
  logic                  take;
  logic                  start;

  assign start = start_i & ~busy_q;

  // One extra bit keeps the credit sum from wrapping
  assign credit_ok = ({1'b0, outst_q} + {1'b0, fifo_count}) <
                     (LOAD_CNT_W + 1)'(LOAD_FIFO_DEPTH);

  assign tcdm.req  = busy_q & enable_i & (req_left_q != '0) & credit_ok;
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = 1'b1;
  assign tcdm.be   = '1;
  assign tcdm.data = '0;
  assign issue     = tcdm.req & tcdm.gnt;

  stream_fifo #(
    .payload_t ( data_t          ),
    .DEPTH     ( LOAD_FIFO_DEPTH )
  ) i_load_fifo (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .clear_i     ( clear_i      ),
    .push_i      ( tcdm.r_valid ),
    .push_data_i ( tcdm.r_data  ),
    .full_o      (              ),
    .pop_i       ( take         ),
    .pop_data_o  ( data_o       ),
    .empty_o     ( fifo_empty   ),
    .count_o     ( fifo_count   )
  );

  assign valid_o = ~fifo_empty;
  assign take    = valid_o & ready_i;
  assign busy_o  = busy_q;
  assign done_o  = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      req_left_q <= '0;
      out_left_q <= '0;
      outst_q    <= '0;
    end else begin
      done_q  <= 1'b0;
      outst_q <= outst_q + LOAD_CNT_W'(issue) - LOAD_CNT_W'(tcdm.r_valid);
      if (start) begin
        busy_q     <= (len_i != '0);
        done_q     <= (len_i == '0);
        req_left_q <= len_i;
        out_left_q <= len_i;
      end else if (busy_q) begin
        if (issue) begin
          req_left_q <= req_left_q - 1'b1;
        end
        // Last word leaving the stream ends the run
        if (take) begin
          out_left_q <= out_left_q - 1'b1;
          if (out_left_q == LEN_W'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (issue) begin
      addr_q <= addr_q + ADDR_W'(stride_q);
    end
  end

endmodule

//--- logic/stream_sink.sv
/* Store channel: writes len_i stream words to base_i + i*stride_i, all bytes enabled.
   Done follows the grant of the last write. A start with len_i of zero only pulses done. */

`timescale 1ns/10ps

module stream_sink
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              enable_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_i,
  input  logic [LEN_W-1:0]  stride_i,
  input  logic [LEN_W-1:0]  len_i,
  output logic              busy_o,
  output logic              done_o,
  tcdm_if.initiator         tcdm,
  input  logic              valid_i,
  output logic              ready_o,
  input  data_t             data_i
);

  logic              busy_q;
  logic              done_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  stride_q;
  logic [LEN_W-1:0]  acc_left_q;
  logic [LEN_W-1:0]  wr_left_q;
  logic              fifo_full;
  logic              fifo_empty;
  logic              accept;
  logic              retire;
  logic              start;
  mem_req_t          push_req;
  mem_req_t          head_req;

  assign start   = start_i & ~busy_q;
  assign ready_o = busy_q & enable_i & (acc_left_q != '0) & ~fifo_full;
  assign accept  = valid_i & ready_o;

  // Each accepted word becomes a full-word write at the running address
  assign push_req.add  = addr_q;
  assign push_req.wen  = 1'b0;
  assign push_req.be   = '1;
  assign push_req.data = data_i;

  stream_fifo #(
    .payload_t ( mem_req_t        ),
    .DEPTH     ( STORE_FIFO_DEPTH )
  ) i_store_fifo (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .clear_i     ( clear_i    ),
    .push_i      ( accept     ),
    .push_data_i ( push_req   ),
    .full_o      ( fifo_full  ),
    .pop_i       ( retire     ),
    .pop_data_o  ( head_req   ),
    .empty_o     ( fifo_empty ),
    .count_o     (            )
  );

  assign tcdm.req  = ~fifo_empty;
  assign tcdm.add  = head_req.add;
  assign tcdm.wen  = head_req.wen;
  assign tcdm.be   = head_req.be;
  assign tcdm.data = head_req.data;
  assign retire    = tcdm.req & tcdm.gnt;

  assign busy_o = busy_q;
  assign done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      acc_left_q <= '0;
      wr_left_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q     <= (len_i != '0);
        done_q     <= (len_i == '0);
        acc_left_q <= len_i;
        wr_left_q  <= len_i;
      end else if (busy_q) begin
        if (accept) begin
          acc_left_q <= acc_left_q - 1'b1;
        end
        if (retire) begin
          wr_left_q <= wr_left_q - 1'b1;
          if (wr_left_q == LEN_W'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (accept) begin
      addr_q <= addr_q + ADDR_W'(stride_q);
    end
  end

endmodule

//--- logic/tcdm_mux.sv
/* Round-robin arbiter of N_CHAN channels onto one memory port.
   A waiting request keeps the port until granted. Only the owner of the last
   granted read sees the next-cycle response, so write cycles are filtered out. */

`timescale 1ns/10ps

module tcdm_mux
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  tcdm_if.target            chan [N_CHAN],
  output logic              mem_req_o,
  input  logic              mem_gnt_i,
  output logic [ADDR_W-1:0] mem_add_o,
  output logic              mem_wen_o,
  output logic [BE_W-1:0]   mem_be_o,
  output data_t             mem_data_o,
  input  logic              mem_r_valid_i,
  input  data_t             mem_r_data_i
);

  logic [N_CHAN-1:0] req_v;
  logic [N_CHAN-1:0] wen_v;
  logic [ADDR_W-1:0] add_v [N_CHAN];
  logic [BE_W-1:0]   be_v [N_CHAN];
  data_t             data_v [N_CHAN];
  logic [CHAN_W-1:0] prio_q;
  logic [CHAN_W-1:0] rr_sel;
  logic [CHAN_W-1:0] sel;
  logic [CHAN_W-1:0] lock_idx_q;
  logic [CHAN_W-1:0] owner_q;
  logic              lock_q;
  logic              owner_vld_q;
  logic              xfer;

  for (genvar g = 0; g < N_CHAN; g++) begin : gen_chan
    assign req_v[g]  = chan[g].req;
    assign wen_v[g]  = chan[g].wen;
    assign add_v[g]  = chan[g].add;
    assign be_v[g]   = chan[g].be;
    assign data_v[g] = chan[g].data;

    assign chan[g].gnt     = mem_gnt_i & req_v[g] & (sel == CHAN_W'(g));
    assign chan[g].r_valid = mem_r_valid_i & owner_vld_q & (owner_q == CHAN_W'(g));
    assign chan[g].r_data  = mem_r_data_i;
  end

  // First requester at or after prio_q; walking down leaves the nearest one
  always_comb begin
    rr_sel = prio_q;
    for (int k = N_CHAN - 1; k >= 0; k--) begin
      if (req_v[(int'(prio_q) + k) % N_CHAN]) begin
        rr_sel = CHAN_W'((int'(prio_q) + k) % N_CHAN);
      end
    end
  end

  assign sel        = lock_q ? lock_idx_q : rr_sel;
  assign mem_req_o  = req_v[sel];
  assign mem_add_o  = add_v[sel];
  assign mem_wen_o  = wen_v[sel];
  assign mem_be_o   = be_v[sel];
  assign mem_data_o = data_v[sel];
  assign xfer       = mem_req_o & mem_gnt_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      prio_q      <= '0;
      lock_q      <= 1'b0;
      lock_idx_q  <= '0;
      owner_vld_q <= 1'b0;
      owner_q     <= '0;
    end else begin
      // Hold the winner while it waits for mem_gnt_i
      lock_q      <= mem_req_o & ~mem_gnt_i;
      lock_idx_q  <= sel;
      owner_vld_q <= xfer & mem_wen_o;
      if (xfer) begin
        owner_q <= sel;
        prio_q  <= (sel == CHAN_W'(N_CHAN - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

endmodule

//--- logic/streamer.sv
/* Memory streamer top: X and W load streams, Z store stream, one shared memory port.
   Data passes unchanged. Control ports are per channel; start is a one-cycle pulse. */

`timescale 1ns/10ps

module streamer
  import streamer_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              enable_i,

  // Memory port
  output logic              mem_req_o,
  input  logic              mem_gnt_i,
  output logic [ADDR_W-1:0] mem_add_o,
  output logic              mem_wen_o,
  output logic [BE_W-1:0]   mem_be_o,
  output data_t             mem_data_o,
  input  logic              mem_r_valid_i,
  input  data_t             mem_r_data_i,

  // Streams
  output logic              x_valid_o,
  input  logic              x_ready_i,
  output data_t             x_data_o,
  output logic              w_valid_o,
  input  logic              w_ready_i,
  output data_t             w_data_o,
  input  logic              z_valid_i,
  output logic              z_ready_o,
  input  data_t             z_data_i,

  // X control
  input  logic              x_start_i,
  input  logic [ADDR_W-1:0] x_base_i,
  input  logic [LEN_W-1:0]  x_stride_i,
  input  logic [LEN_W-1:0]  x_len_i,
  output logic              x_busy_o,
  output logic              x_done_o,

  // W control
  input  logic              w_start_i,
  input  logic [ADDR_W-1:0] w_base_i,
  input  logic [LEN_W-1:0]  w_stride_i,
  input  logic [LEN_W-1:0]  w_len_i,
  output logic              w_busy_o,
  output logic              w_done_o,

  // Z control
  input  logic              z_start_i,
  input  logic [ADDR_W-1:0] z_base_i,
  input  logic [LEN_W-1:0]  z_stride_i,
  input  logic [LEN_W-1:0]  z_len_i,
  output logic              z_busy_o,
  output logic              z_done_o
);

  // One memory channel per stream, indexed by CH_X, CH_W and CH_Z
  tcdm_if chan_if [N_CHAN] ();

  stream_source i_x_source (
    .clk_i    ( clk_i           ),
    .rst_n_i  ( rst_n_i         ),
    .clear_i  ( clear_i         ),
    .enable_i ( enable_i        ),
    .start_i  ( x_start_i       ),
    .base_i   ( x_base_i        ),
    .stride_i ( x_stride_i      ),
    .len_i    ( x_len_i         ),
    .busy_o   ( x_busy_o        ),
    .done_o   ( x_done_o        ),
    .tcdm     ( chan_if[CH_X]   ),
    .valid_o  ( x_valid_o       ),
    .ready_i  ( x_ready_i       ),
    .data_o   ( x_data_o        )
  );

  stream_source i_w_source (
    .clk_i    ( clk_i           ),
    .rst_n_i  ( rst_n_i         ),
    .clear_i  ( clear_i         ),
    .enable_i ( enable_i        ),
    .start_i  ( w_start_i       ),
    .base_i   ( w_base_i        ),
    .stride_i ( w_stride_i      ),
    .len_i    ( w_len_i         ),
    .busy_o   ( w_busy_o        ),
    .done_o   ( w_done_o        ),
    .tcdm     ( chan_if[CH_W]   ),
    .valid_o  ( w_valid_o       ),
    .ready_i  ( w_ready_i       ),
    .data_o   ( w_data_o        )
  );

  stream_sink i_z_sink (
    .clk_i    ( clk_i           ),
    .rst_n_i  ( rst_n_i         ),
    .clear_i  ( clear_i         ),
    .enable_i ( enable_i        ),
    .start_i  ( z_start_i       ),
    .base_i   ( z_base_i        ),
    .stride_i ( z_stride_i      ),
    .len_i    ( z_len_i         ),
    .busy_o   ( z_busy_o        ),
    .done_o   ( z_done_o        ),
    .tcdm     ( chan_if[CH_Z]   ),
    .valid_i  ( z_valid_i       ),
    .ready_o  ( z_ready_o       ),
    .data_i   ( z_data_i        )
  );

  tcdm_mux i_mux (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .clear_i       ( clear_i       ),
    .chan          ( chan_if       ),
    .mem_req_o     ( mem_req_o     ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_be_o      ( mem_be_o      ),
    .mem_data_o    ( mem_data_o    ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .mem_r_data_i  ( mem_r_data_i  )
  );

endmodule

//--- test/streamer_asserts.sv
/* Protocol checks bound to the streamer top. Channel response lines are taken
   from the internal channel interfaces; everything else is a top-level port. */

`timescale 1ns/10ps

module streamer_asserts
  import streamer_pkg::*;
(
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              clear_i,
  input logic              mem_req_o,
  input logic              mem_gnt_i,
  input logic [ADDR_W-1:0] mem_add_o,
  input logic              mem_wen_o,
  input logic [BE_W-1:0]   mem_be_o,
  input data_t             mem_data_o,
  input logic              x_valid_o,
  input logic              x_ready_i,
  input data_t             x_data_o,
  input logic              w_valid_o,
  input logic              w_ready_i,
  input data_t             w_data_o,
  input logic              x_busy_o,
  input logic              x_done_o,
  input logic              w_busy_o,
  input logic              w_done_o,
  input logic              z_busy_o,
  input logic              z_done_o,
  input logic [N_CHAN-1:0] chan_r_valid
);

  // A waiting request keeps all its fields until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_add_o) && $stable(mem_wen_o)
      && $stable(mem_be_o) && $stable(mem_data_o))
    else $error("memory request changed before its grant");

  x_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    x_valid_o && !x_ready_i |=> x_valid_o && $stable(x_data_o))
    else $error("X stream word changed while waiting for ready");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else $error("W stream word changed while waiting for ready");

  // The cycle after a granted write belongs to no reader
  write_filtered: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    mem_req_o && mem_gnt_i && !mem_wen_o |=> chan_r_valid == '0)
    else $error("response delivered to a channel after a write grant");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !(x_busy_o || x_done_o || w_busy_o || w_done_o || z_busy_o || z_done_o))
    else $error("busy or done high during reset");

endmodule

//--- test/tb_streamer.sv
/* Random test of the streamer against a 1024-word memory model, seed 71.
   X and W read below word 256; Z writes from word 512 up, so regions never overlap. */

`timescale 1ns/10ps

module tb_streamer
  import streamer_pkg::*;
();

  localparam int CLK_P        = 4;
  localparam int RESET_CYCLES = 16;
  localparam int MEM_WORDS    = 1024;
  // Words moved over all tests, sets the watchdog budget
  localparam int TOTAL_WORDS  = 20 + 32 + 16 + 36 + 18;
  localparam int WATCHDOG_NS  = (TOTAL_WORDS * 40 + 200) * CLK_P;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b0;
  logic clear_i = 1'b0;
  logic enable_i = 1'b1;
  logic mem_req_o, mem_wen_o;
  logic mem_gnt_i = 1'b0;
  logic mem_r_valid_i = 1'b0;
  logic [ADDR_W-1:0] mem_add_o;
  logic [BE_W-1:0] mem_be_o;
  data_t mem_data_o;
  data_t mem_r_data_i = '0;
  logic x_valid_o, w_valid_o, z_ready_o;
  logic x_ready_i = 1'b0;
  logic w_ready_i = 1'b0;
  logic z_valid_i = 1'b0;
  data_t x_data_o, w_data_o;
  data_t z_data_i = '0;
  logic x_start_i = 1'b0;
  logic w_start_i = 1'b0;
  logic z_start_i = 1'b0;
  logic [ADDR_W-1:0] x_base_i = '0, w_base_i = '0, z_base_i = '0;
  logic [LEN_W-1:0] x_stride_i = '0, w_stride_i = '0, z_stride_i = '0;
  logic [LEN_W-1:0] x_len_i = '0, w_len_i = '0, z_len_i = '0;
  logic x_busy_o, x_done_o, w_busy_o, w_done_o, z_busy_o, z_done_o;

  data_t init_mem [MEM_WORDS];
  data_t exp_mem [MEM_WORDS];
  data_t mem_model [MEM_WORDS];
  data_t z_word [64];
  logic mem_loaded = 1'b0;
  int x_got = 0, w_got = 0, z_sent = 0, x_first = 0, w_first = 0, z_first = 0;
  int x_dones = 0, w_dones = 0, z_dones = 0;
  int mem_errors = 0, stream_errors = 0, ctrl_errors = 0;

  streamer dut_i (.*);

  bind streamer streamer_asserts i_asserts (
    .*,
    .chan_r_valid ({chan_if[2].r_valid, chan_if[1].r_valid, chan_if[0].r_valid})
  );

  always #(CLK_P / 2) clk_i = ~clk_i;

  function automatic int word_index(logic [ADDR_W-1:0] addr);
    return int'(addr[11:2]);
  endfunction

  // Memory model, random grants and stream back-pressure
  always @(posedge clk_i) begin
    if (!mem_loaded) begin
      for (int k = 0; k < MEM_WORDS; k++) begin
        mem_model[k] = init_mem[k];
      end
      mem_loaded = 1'b1;
    end
    mem_r_valid_i <= 1'b0;
    if (mem_req_o && mem_gnt_i) begin
      // Writes also answer with a response cycle that the mux must drop
      mem_r_valid_i <= 1'b1;
      mem_r_data_i  <= mem_model[word_index(mem_add_o)];
      if (!mem_wen_o) begin
        assert (mem_be_o == '1) else begin
          $display("CHECK FAILED @%0t: write byte enables %b", $time, mem_be_o);
          mem_errors++;
        end
        mem_model[word_index(mem_add_o)] = mem_data_o;
      end
    end
    mem_gnt_i <= ($urandom % 3) != 0;
    x_ready_i <= ($urandom % 4) != 0;
    w_ready_i <= ($urandom % 3) != 0;
  end

  // Stream monitors against mem[base + i*stride]
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (x_valid_o && x_ready_i) begin
        assert (x_got - x_first < int'(x_len_i) && x_data_o ==
                init_mem[word_index(x_base_i + ADDR_W'((x_got - x_first) * x_stride_i))])
        else begin
          $display("CHECK FAILED @%0t: X word %0d is %h", $time, x_got - x_first, x_data_o);
          stream_errors++;
        end
        x_got++;
      end
      if (w_valid_o && w_ready_i) begin
        assert (w_got - w_first < int'(w_len_i) && w_data_o ==
                init_mem[word_index(w_base_i + ADDR_W'((w_got - w_first) * w_stride_i))])
        else begin
          $display("CHECK FAILED @%0t: W word %0d is %h", $time, w_got - w_first, w_data_o);
          stream_errors++;
        end
        w_got++;
      end
      x_dones += int'(x_done_o);
      w_dones += int'(w_done_o);
      z_dones += int'(z_done_o);
    end
  end

  // Z stream driver, a word stays valid until taken
  always @(posedge clk_i) begin
    int nxt;
    if (!rst_n_i) begin
      z_valid_i <= 1'b0;
    end else if (!(z_valid_i && !z_ready_o)) begin
      if (z_valid_i) z_sent = z_sent + 1;
      nxt = z_sent - z_first;
      if (nxt < int'(z_len_i) && ($urandom % 3) != 0) begin
        z_valid_i <= 1'b1;
        z_data_i  <= z_word[nxt];
      end else begin
        z_valid_i <= 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout: the tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic setup_loads(input int nx, input int nw);
    int x_step;
    int w_step;
    x_first = x_got;
    w_first = w_got;
    x_step = 1 + $urandom % 4;
    // W always gets another stride and a base above every X base
    w_step = 1 + (x_step + $urandom % 3) % 4;
    x_base_i   <= ADDR_W'(4 * ($urandom % 128));
    w_base_i   <= ADDR_W'(4 * (128 + $urandom % 64));
    x_stride_i <= LEN_W'(4 * x_step);
    w_stride_i <= LEN_W'(4 * w_step);
    x_len_i    <= LEN_W'(nx);
    w_len_i    <= LEN_W'(nw);
  endtask

  task automatic setup_store(input int nz);
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  stride;
    addr   = ADDR_W'(2048 + 4 * ($urandom % 64));
    stride = LEN_W'(4 * (1 + $urandom % 4));
    // Words are in place before the driver can see the new run
    for (int i = 0; i < nz; i++) begin
      z_word[i] = $urandom;
      exp_mem[word_index(addr + ADDR_W'(i * stride))] = z_word[i];
    end
    z_first = z_sent;
    z_base_i   <= addr;
    z_stride_i <= stride;
    z_len_i    <= LEN_W'(nz);
  endtask

  // Start the chosen channels together, then wait for each done
  task automatic run_channels(input bit rx, input bit rw, input bit rz);
    int xd0;
    int wd0;
    int zd0;
    xd0 = x_dones;
    wd0 = w_dones;
    zd0 = z_dones;
    @(posedge clk_i);
    x_start_i <= rx;
    w_start_i <= rw;
    z_start_i <= rz;
    @(posedge clk_i);
    x_start_i <= 1'b0;
    w_start_i <= 1'b0;
    z_start_i <= 1'b0;
    while ((rx && x_dones == xd0) || (rw && w_dones == wd0) || (rz && z_dones == zd0))
      @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    assert (x_dones - xd0 == int'(rx) && w_dones - wd0 == int'(rw) && z_dones - zd0 == int'(rz))
    else begin
      $display("Done did not pulse exactly once per started channel");
      ctrl_errors++;
    end
    assert (!x_busy_o && !w_busy_o && !z_busy_o) else begin
      $display("Busy still high after done");
      ctrl_errors++;
    end
    assert ((!rx || x_got - x_first == int'(x_len_i)) && (!rw || w_got - w_first == int'(w_len_i)))
    else begin
      $display("CHECK FAILED @%0t: load stream word count wrong", $time);
      stream_errors++;
    end
  endtask

  task automatic compare_memory();
    for (int k = 0; k < MEM_WORDS; k++) begin
      assert (mem_model[k] == exp_mem[k]) else begin
        $display("CHECK FAILED @%0t: mem word %0d is %h exp %h", $time, k, mem_model[k],
                 exp_mem[k]);
        mem_errors++;
      end
    end
  endtask

  task automatic clear_midrun();
    setup_loads(12, 0);
    @(posedge clk_i);
    x_start_i <= 1'b1;
    @(posedge clk_i);
    x_start_i <= 1'b0;
    while (x_got - x_first < 3) @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    repeat (10) begin
      @(posedge clk_i);
      assert (!mem_req_o && !x_busy_o && !x_valid_o) else begin
        $display("Activity after clear without a new start");
        ctrl_errors++;
      end
    end
  endtask

  initial begin
    void'($urandom(71));
    for (int k = 0; k < MEM_WORDS; k++) begin
      init_mem[k] = $urandom;
      exp_mem[k]  = init_mem[k];
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    setup_loads(20, 0);
    run_channels(1'b1, 1'b0, 1'b0);
    setup_loads(16, 16);
    run_channels(1'b1, 1'b1, 1'b0);
    setup_store(16);
    run_channels(1'b0, 1'b0, 1'b1);
    compare_memory();
    setup_loads(12, 12);
    setup_store(12);
    run_channels(1'b1, 1'b1, 1'b1);
    compare_memory();
    clear_midrun();
    setup_loads(6, 0);
    run_channels(1'b1, 1'b0, 1'b0);
    $display("Errors: memory %0d, stream %0d, control %0d", mem_errors, stream_errors,
             ctrl_errors);
    if (mem_errors + stream_errors + ctrl_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/streamer_pkg.sv
logic/tcdm_if.sv
logic/stream_fifo.sv
logic/stream_source.sv
logic/stream_sink.sv
logic/tcdm_mux.sv
logic/streamer.sv
test/streamer_asserts.sv
test/tb_streamer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_streamer
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Result: failed"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "Result: no verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
